//--- flist.f
+incdir+include
src/mosfet_pkg.sv
src/result_pkg.sv
src/mosfet_if.sv
src/operand_capture.sv
src/drain_current_bank.sv
src/transconductance_bank.sv
src/rank_average.sv
src/smc_top.sv
testbench/smc_checker.sv
testbench/smc_tb.sv

//--- Makefile
# Verilator build and run of the MOSFET calculator testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= smc_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/smc_tb.sv
//==========================================================================
// testbench for the MOSFET calculator
// random operands from a fixed seed, V_GS drawn from 1 to 7
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "smc_macros.svh"

module smc_tb;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    result_pkg::mode_t        mode;
    mosfet_pkg::operand_arr_t w;
    mosfet_pkg::operand_arr_t vgs;
    mosfet_pkg::operand_arr_t vds;
    logic                     out_valid;
    result_pkg::metric_t      out_n;
    logic                     done;
    int                       errors;
    int                       checks;
    int                       pending;
    int                       tb_errors;
    int                       sent;
    int                       err_mark;
    int                       chk_mark;

    always #20 clk = ~clk;

    smc_top smc_top_i (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_in_valid  (in_valid),
        .i_mode      (mode),
        .i_w         (w),
        .i_vgs       (vgs),
        .i_vds       (vds),
        .o_out_valid (out_valid),
        .o_out_n     (out_n)
    );

    smc_checker smc_checker_i (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_in_valid  (in_valid),
        .i_mode      (mode),
        .i_w         (w),
        .i_vgs       (vgs),
        .i_vds       (vds),
        .i_out_valid (out_valid),
        .i_out_n     (out_n),
        .i_done      (done),
        .o_errors    (errors),
        .o_checks    (checks),
        .o_pending   (pending)
    );

    // same gives six identical devices
    task automatic drive_sample(input result_pkg::mode_t m, input bit same);
        mosfet_pkg::operand_arr_t nw;
        mosfet_pkg::operand_arr_t ng;
        mosfet_pkg::operand_arr_t nd;
        for (int d = 0; d < `SMC_NUM_DEVICES; d++) begin
            nw[d] = mosfet_pkg::operand_t'($urandom_range(7, 0));
            ng[d] = mosfet_pkg::operand_t'($urandom_range(7, 1));
            nd[d] = mosfet_pkg::operand_t'($urandom_range(7, 0));
        end
        if (same) begin
            nw = {`SMC_NUM_DEVICES{nw[0]}};
            ng = {`SMC_NUM_DEVICES{ng[0]}};
            nd = {`SMC_NUM_DEVICES{nd[0]}};
        end
        @(posedge clk);
        in_valid <= 1'b1;
        mode     <= m;
        w        <= nw;
        vgs      <= ng;
        vds      <= nd;
        sent++;
    endtask

    // stop input, wait for the pipeline to drain, print one line
    task automatic finish_test(input string name);
        int n;
        int errs;
        @(posedge clk);
        in_valid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (pending != 0 && n < 20);
        if (pending != 0) begin
            $display("test %s: timed out waiting for results", name);
            tb_errors++;
        end
        if (checks - chk_mark != sent) begin
            $display("test %s: %0d results for %0d samples", name, checks - chk_mark, sent);
            tb_errors++;
        end
        errs = errors + tb_errors - err_mark;
        $display("test %s: %0d samples, %0d errors", name, sent, errs);
        err_mark = errors + tb_errors;
        chk_mark = checks;
        sent     = 0;
    endtask

    initial begin
        void'($urandom(32'h0dde6ecf));
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        mode      = '0;
        w         = '0;
        vgs       = {`SMC_NUM_DEVICES{3'd1}};
        vds       = '0;
        done      = 1'b0;
        tb_errors = 0;
        sent      = 0;
        err_mark  = 0;
        chk_mark  = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int c = 0; c < 12; c++) begin
            @(posedge clk);
            if (out_valid !== 1'b0) begin
                $display("o_out_valid high at %0t with no sample sent", $time);
                tb_errors++;
            end
        end
        finish_test("idle after reset");

        repeat (24) drive_sample(2'b11, 1'b0);
        finish_test("current, largest three");

        // equal devices give ties in every rank
        repeat (8) drive_sample(2'b01, 1'b1);
        repeat (16) drive_sample(2'b01, 1'b0);
        finish_test("current, smallest three");

        repeat (12) begin
            drive_sample(2'b10, 1'b0);
            drive_sample(2'b00, 1'b0);
        end
        finish_test("transconductance, both");

        repeat (40) drive_sample(result_pkg::mode_t'($urandom_range(3, 0)), 1'b0);
        finish_test("burst, mixed modes");

        done <= 1'b1;
        repeat (2) @(posedge clk);
        $display("results checked %0d, errors %0d", checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/smc_checker.sv
//==========================================================================
// scoreboard for the MOSFET calculator
// each result is expected exactly three cycles after its sample
// reference assumes V_GS of at least 1, the stimulus never drives 0
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "smc_macros.svh"

module smc_checker (
    input  wire                      i_clk,
    input  wire                      i_reset,
    input  wire                      i_in_valid,
    input  result_pkg::mode_t        i_mode,
    input  mosfet_pkg::operand_arr_t i_w,
    input  mosfet_pkg::operand_arr_t i_vgs,
    input  mosfet_pkg::operand_arr_t i_vds,
    input  wire                      i_out_valid,
    input  result_pkg::metric_t      i_out_n,
    input  wire                      i_done,
    output int                       o_errors,
    output int                       o_checks,
    output int                       o_pending
);

    int exp_q [$];
    int due_q [$];
    int cycle;
    int errors;
    int checks;
    bit leftover_seen;

    // device metrics, full descending sort, then the two averages
    function automatic int expected_result(input result_pkg::mode_t        m,
                                           input mosfet_pkg::operand_arr_t w,
                                           input mosfet_pkg::operand_arr_t vgs,
                                           input mosfet_pkg::operand_arr_t vds);
        int v [`SMC_NUM_DEVICES];
        int ov;
        int vd;
        int wd;
        int tmp;
        int base;
        int b0;
        int b1;
        int b2;
        for (int d = 0; d < `SMC_NUM_DEVICES; d++) begin
            ov = int'(vgs[d]) - 1;
            vd = int'(vds[d]);
            wd = int'(w[d]);
            if (m[`SMC_MODE_CURRENT_BIT]) begin
                v[d] = (ov > vd) ? wd * (2 * ov * vd - vd * vd) : wd * ov * ov;
            end else begin
                v[d] = (ov > vd) ? 2 * wd * vd : 2 * wd * ov;
            end
        end
        for (int i = 0; i < `SMC_NUM_DEVICES - 1; i++) begin
            for (int j = 0; j < `SMC_NUM_DEVICES - 1 - i; j++) begin
                if (v[j] < v[j+1]) begin
                    tmp    = v[j];
                    v[j]   = v[j+1];
                    v[j+1] = tmp;
                end
            end
        end
        // smallest three sit at the tail, still descending
        base = m[`SMC_MODE_LARGEST_BIT] ? 0 : `SMC_NUM_DEVICES - 3;
        b0 = v[base] / 3;
        b1 = v[base+1] / 3;
        b2 = v[base+2] / 3;
        if (m[`SMC_MODE_CURRENT_BIT]) begin
            return ((3 * b0 + 4 * b1 + 5 * b2) / 4) / 3;
        end
        return (b0 + b1 + b2) / 3;
    endfunction

    always @(posedge i_clk) begin
        int exp;
        int due;
        cycle++;
        if (!i_reset) begin
            if (i_out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("result %0d arrived at %0t with no pending sample", i_out_n, $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    due = due_q.pop_front();
                    checks++;
                    if (due != cycle) begin
                        $display("result arrived in cycle %0d, expected in cycle %0d", cycle, due);
                        errors++;
                    end
                    if ($isunknown(i_out_n) || int'(i_out_n) != exp) begin
                        $display("MISMATCH at %0t: expected %0d, got %0d", $time, exp, i_out_n);
                        errors++;
                    end
                end
            end else if (due_q.size() != 0 && due_q[0] == cycle) begin
                $display("no result in cycle %0d for a pending sample", cycle);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                errors++;
            end
            if (i_in_valid) begin
                exp_q.push_back(expected_result(i_mode, i_w, i_vgs, i_vds));
                due_q.push_back(cycle + 3);
            end
        end
        if (i_done && !leftover_seen) begin
            leftover_seen = 1'b1;
            if (exp_q.size() != 0) begin
                $display("%0d samples still pending at end of run", exp_q.size());
                errors++;
            end
        end
        o_errors  <= errors;
        o_checks  <= checks;
        o_pending <= exp_q.size();
    end

endmodule

`default_nettype wire

//--- src/smc_top.sv
//==========================================================================
// MOSFET calculator top level
// result appears three cycles after each accepted sample
// no back-pressure, every result must be taken
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module smc_top (
    input  wire                      i_clk,
    input  wire                      i_reset,
    input  wire                      i_in_valid,
    input  result_pkg::mode_t        i_mode,
    input  mosfet_pkg::operand_arr_t i_w,
    input  mosfet_pkg::operand_arr_t i_vgs,
    input  mosfet_pkg::operand_arr_t i_vds,
    output logic                     o_out_valid,
    output result_pkg::metric_t      o_out_n
);

    mosfet_if ops_if ();

    result_pkg::metric_arr_t current;
    result_pkg::metric_arr_t gm;

    operand_capture operand_capture_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_in_valid (i_in_valid),
        .i_mode     (i_mode),
        .i_w        (i_w),
        .i_vgs      (i_vgs),
        .i_vds      (i_vds),
        .o_ops      (ops_if.capture)
    );

    // both banks run side by side
    drain_current_bank drain_current_bank_i (
        .i_clk      (i_clk),
        .i_ops      (ops_if.bank),
        .o_current  (current)
    );

    transconductance_bank transconductance_bank_i (
        .i_clk      (i_clk),
        .i_ops      (ops_if.bank),
        .o_gm       (gm)
    );

    rank_average rank_average_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_ops       (ops_if.bank),
        .i_current   (current),
        .i_gm        (gm),
        .o_out_valid (o_out_valid),
        .o_out_n     (o_out_n)
    );

endmodule

`default_nettype wire

//--- src/rank_average.sv
//==========================================================================
// metric select, top/bottom three ranking and averaging
// valid and mode are delayed one cycle to meet the bank outputs
// output register holds its value between results
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "smc_macros.svh"

module rank_average (
    input  wire                       i_clk,
    input  wire                       i_reset,
    mosfet_if.bank                    i_ops,
    input  result_pkg::metric_arr_t   i_current,
    input  result_pkg::metric_arr_t   i_gm,
    output logic                      o_out_valid,
    output result_pkg::metric_t       o_out_n
);

    // two spare bits for the overflow check
    typedef logic [`SMC_SUM_BITS+1:0] wide_sum_t;

    logic                    valid_d;
    result_pkg::mode_t       mode_d;
    logic                    largest;
    result_pkg::metric_arr_t pick;
    result_pkg::metric_t     cand;
    result_pkg::metric_t     spill;
    result_pkg::metric_t     keep [`SMC_RANK_DEPTH];
    result_pkg::metric_t     part [`SMC_RANK_DEPTH];
    wide_sum_t               wsum_full;
    result_pkg::sum_t        wsum;
    result_pkg::sum_t        gm_sum;
    result_pkg::metric_t     cur_avg;
    result_pkg::metric_t     gm_avg;

    function automatic logic beats(input result_pkg::metric_t a,
                                   input result_pkg::metric_t b,
                                   input logic                big);
        return big ? (a > b) : (a < b);
    endfunction

    //==========================================================================
    // align with bank outputs
    //==========================================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_d     <= 1'b0;
            o_out_valid <= 1'b0;
        end else begin
            valid_d     <= i_ops.valid;
            o_out_valid <= valid_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ops.valid) begin
            mode_d <= i_ops.mode;
        end
        if (valid_d) begin
            o_out_n <= mode_d[`SMC_MODE_CURRENT_BIT] ? cur_avg : gm_avg;
        end
    end

    //==========================================================================
    // ranking, keep[0] is the best candidate so far
    //==========================================================================
    assign largest = mode_d[`SMC_MODE_LARGEST_BIT];
    assign pick    = mode_d[`SMC_MODE_CURRENT_BIT] ? i_current : i_gm;

    always_comb begin
        for (int k = 0; k < `SMC_RANK_DEPTH; k++) begin
            keep[k] = largest ? '0 : '1;
        end
        cand  = '0;
        spill = '0;
        for (int d = 0; d < `SMC_NUM_DEVICES; d++) begin
            cand = pick[d];
            // candidate sinks, displaced entries move one slot down
            for (int k = 0; k < `SMC_RANK_DEPTH; k++) begin
                if (beats(cand, keep[k], largest)) begin
                    spill   = keep[k];
                    keep[k] = cand;
                    cand    = spill;
                end
            end
        end
    end

    // descending order r0 >= r1 >= r2, then each divided by three
    always_comb begin
        for (int k = 0; k < `SMC_RANK_DEPTH; k++) begin
            part[k] = (largest ? keep[k] : keep[`SMC_RANK_DEPTH-1-k])
                      / result_pkg::metric_t'(3);
        end
    end

    //==========================================================================
    // averages
    //==========================================================================
    assign wsum_full = wide_sum_t'(`SMC_WEIGHT_0) * part[0]
                     + wide_sum_t'(`SMC_WEIGHT_1) * part[1]
                     + wide_sum_t'(`SMC_WEIGHT_2) * part[2];
    assign wsum      = wsum_full[`SMC_SUM_BITS-1:0];
    assign gm_sum    = part[0] + part[1] + part[2];

    // weights add to twelve, so divide by four and then by three
    assign cur_avg = result_pkg::metric_t'((wsum >> 2)
                     / result_pkg::sum_t'(`SMC_RANK_DEPTH));
    assign gm_avg  = result_pkg::metric_t'(gm_sum
                     / result_pkg::sum_t'(`SMC_RANK_DEPTH));

    a_wsum_fits: assert property (@(posedge i_clk) disable iff (i_reset)
        valid_d |-> wsum_full[`SMC_SUM_BITS+1:`SMC_SUM_BITS] == '0);

endmodule

`default_nettype wire

//--- src/transconductance_bank.sv
//==========================================================================
// transconductance for six devices, one cycle
// triode 2 * W * Vds, saturation 2 * W * Vov
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "smc_macros.svh"

module transconductance_bank (
    input  wire                       i_clk,
    mosfet_if.bank                    i_ops,
    output result_pkg::metric_arr_t   o_gm
);

    result_pkg::metric_arr_t gm_next;

    for (genvar d = 0; d < `SMC_NUM_DEVICES; d++) begin : g_dev

        // region picks the voltage term
        assign gm_next[d] = (i_ops.w[d] * (i_ops.triode[d] ? i_ops.vds[d]
                                                          : i_ops.overdrive[d])) << 1;

        // registered value one cycle later stays within 2 * 7 * 6
        a_gm_range: assert property (@(posedge i_clk)
            i_ops.valid |=> o_gm[d] <= result_pkg::metric_t'(84));

    end

    always_ff @(posedge i_clk) begin
        if (i_ops.valid) begin
            o_gm <= gm_next;
        end
    end

endmodule

`default_nettype wire

//--- src/drain_current_bank.sv
//==========================================================================
// drain current for six devices, one cycle
// triode   W * (2 * Vov * Vds - Vds^2)
// saturate W * Vov^2
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "smc_macros.svh"

module drain_current_bank (
    input  wire                       i_clk,
    mosfet_if.bank                    i_ops,
    output result_pkg::metric_arr_t   o_current
);

    // one spare bit so an out-of-range product is visible
    logic [`SMC_METRIC_BITS:0] cur_full [`SMC_NUM_DEVICES];

    for (genvar d = 0; d < `SMC_NUM_DEVICES; d++) begin : g_dev

        assign cur_full[d] = i_ops.triode[d]
            ? i_ops.w[d] * (((i_ops.overdrive[d] * i_ops.vds[d]) << 1)
                            - i_ops.vds[d] * i_ops.vds[d])
            : i_ops.w[d] * i_ops.overdrive[d] * i_ops.overdrive[d];

        // 7 * 6^2 is the largest legal current
        a_current_range: assert property (@(posedge i_clk)
            i_ops.valid |-> cur_full[d] <= (`SMC_METRIC_BITS+1)'(252));

    end

    always_ff @(posedge i_clk) begin
        if (i_ops.valid) begin
            for (int d = 0; d < `SMC_NUM_DEVICES; d++) begin
                o_current[d] <= cur_full[d][`SMC_METRIC_BITS-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/operand_capture.sv
//==========================================================================
// input register stage, one cycle
// V_GS of 0 wraps the overdrive and gives an unspecified result
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "smc_macros.svh"

module operand_capture (
    input  wire                      i_clk,
    input  wire                      i_reset,
    input  wire                      i_in_valid,
    input  result_pkg::mode_t        i_mode,
    input  mosfet_pkg::operand_arr_t i_w,
    input  mosfet_pkg::operand_arr_t i_vgs,
    input  mosfet_pkg::operand_arr_t i_vds,
    mosfet_if.capture                o_ops
);

    mosfet_pkg::operand_arr_t overdrive;
    mosfet_pkg::region_arr_t  triode;

    // overdrive and region decided once for both banks
    always_comb begin
        for (int d = 0; d < `SMC_NUM_DEVICES; d++) begin
            overdrive[d] = i_vgs[d] - mosfet_pkg::operand_t'(1);
            triode[d]    = overdrive[d] > i_vds[d];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ops.valid <= 1'b0;
        end else begin
            o_ops.valid <= i_in_valid;
        end
    end

    // payload loads only on an accepted sample
    always_ff @(posedge i_clk) begin
        if (i_in_valid) begin
            o_ops.mode      <= i_mode;
            o_ops.w         <= i_w;
            o_ops.vds       <= i_vds;
            o_ops.overdrive <= overdrive;
            o_ops.triode    <= triode;
        end
    end

    a_valid_known: assert property (@(posedge i_clk) disable iff (i_reset)
        !$isunknown(o_ops.valid));

endmodule

`default_nettype wire

//--- src/mosfet_if.sv
//==========================================================================
// captured operands for both banks
// data is meaningful whenever valid is high, there is no ready
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

interface mosfet_if;

    logic                     valid;
    result_pkg::mode_t        mode;
    mosfet_pkg::operand_arr_t w;
    mosfet_pkg::operand_arr_t overdrive;
    mosfet_pkg::operand_arr_t vds;
    mosfet_pkg::region_arr_t  triode;

    // capture stage drives everything
    modport capture (output valid, mode, w, overdrive, vds, triode);

    // banks and the ranking stage only read
    modport bank (input valid, mode, w, overdrive, vds, triode);

endinterface

`default_nettype wire

//--- src/result_pkg.sv
//==========================================================================
// metric, sum and mode types
// a metric is a current, a transconductance or the final result
//==========================================================================
`default_nettype none

`include "smc_macros.svh"

package result_pkg;

    typedef logic [`SMC_METRIC_BITS-1:0] metric_t;
    typedef metric_t [`SMC_NUM_DEVICES-1:0] metric_arr_t;

    // weighted sum of the three ranked values
    typedef logic [`SMC_SUM_BITS-1:0] sum_t;

    // bit 0 current/gm, bit 1 largest/smallest
    typedef logic [1:0] mode_t;

endpackage

`default_nettype wire

//--- src/mosfet_pkg.sv
//==========================================================================
// device operand types
// W, V_GS, V_DS and overdrive share one unsigned width
//==========================================================================
`default_nettype none

`include "smc_macros.svh"

package mosfet_pkg;

    // one W, V_GS, V_DS or overdrive value
    typedef logic [`SMC_OPERAND_BITS-1:0] operand_t;

    // one operand per device, index is the device number
    typedef operand_t [`SMC_NUM_DEVICES-1:0] operand_arr_t;

    // 1 marks a device in triode
    typedef logic [`SMC_NUM_DEVICES-1:0] region_arr_t;

endpackage

`default_nettype wire

//--- include/smc_macros.svh
//==========================================================================
// fixed sizes of the MOSFET calculator
// ranking logic assumes six devices and three kept values
// weights apply to rank positions r0, r1 and r2 in that order
//==========================================================================
`ifndef SMC_MACROS_SVH
`define SMC_MACROS_SVH

// device bank
`define SMC_NUM_DEVICES        6
`define SMC_OPERAND_BITS       3

// result widths
`define SMC_METRIC_BITS        8
`define SMC_SUM_BITS           10

// ranking and current-average weights
`define SMC_RANK_DEPTH         3
`define SMC_WEIGHT_0           3
`define SMC_WEIGHT_1           4
`define SMC_WEIGHT_2           5

// mode bit positions
`define SMC_MODE_CURRENT_BIT   0
`define SMC_MODE_LARGEST_BIT   1

`endif
